// File: rhs_assertions.sv
`timescale 1ns/1ps

module rhs_assertions (
    input logic clk,
    input logic rstn,
    input logic cs,
    input logic sclk,
    input logic busy,
    input logic done
);

    bit failed = 1'b0;   // sticky, set by any failing property

    sclk_low_when_deselected: assert property (@(posedge clk) disable iff (!rstn)
        cs |-> !sclk)
        else begin
            failed = 1'b1;
            $error("sclk high while cs is high");
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!rstn)
        done |=> !done)
        else begin
            failed = 1'b1;
            $error("done held for more than one cycle");
        end

    done_while_busy: assert property (@(posedge clk) disable iff (!rstn)
        done |-> busy)
        else begin
            failed = 1'b1;
            $error("done asserted while not busy");
        end

endmodule

bind rhs_controller rhs_assertions assertions_i (
    .clk  (clk),
    .rstn (rstn),
    .cs   (cs),
    .sclk (sclk),
    .busy (busy),
    .done (done)
);

// File: rhs_chip_model.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module rhs_chip_model (
    input  logic                  cs,
    input  logic                  sclk,
    input  logic [`NUM_LANES-1:0] mosi,
    output logic [`NUM_LANES-1:0] miso
);
    import rhs_pkg::*;

    localparam int LOG_DEPTH = 1024;

    rhs_word_t  frame_log  [`NUM_LANES][LOG_DEPTH];   // every frame seen, per lane
    int         frame_cnt  [`NUM_LANES];
    rhs_word_t  rx_sr      [`NUM_LANES];
    rhs_word_t  tx_sr      [`NUM_LANES];
    rhs_word_t  reply_pipe [`NUM_LANES][`CONVERT_DELAY];   // reply of frame n leaves in n+2
    logic [7:0] dac_code   [`NUM_LANES];                   // last value written to reg 3
    int         bit_cnt;

    initial begin
        bit_cnt = 0;
        miso    = '0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            frame_cnt[l] = 0;
            dac_code[l]  = 8'd0;
            for (int d = 0; d < `CONVERT_DELAY; d++)
                reply_pipe[l][d] = '0;
        end
    end

    task automatic clear_log();
        for (int l = 0; l < `NUM_LANES; l++)
            frame_cnt[l] = 0;
    endtask

    always @(negedge cs) begin
        bit_cnt = 0;
        for (int l = 0; l < `NUM_LANES; l++) begin
            tx_sr[l] = reply_pipe[l][0];
            miso[l]  = tx_sr[l][`FRAME_BITS-1];        // first bit ready before sclk rises
        end
    end

    always @(posedge sclk) begin
        if (!cs) begin
            for (int l = 0; l < `NUM_LANES; l++)
                rx_sr[l] = {rx_sr[l][`FRAME_BITS-2:0], mosi[l]};
            bit_cnt++;
        end
    end

    always @(negedge sclk) begin
        if (!cs) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                tx_sr[l] = {tx_sr[l][`FRAME_BITS-2:0], 1'b0};
                miso[l]  = tx_sr[l][`FRAME_BITS-1];
            end
        end
    end

    // decode a complete frame on every lane
    always @(posedge cs) begin
        rhs_cmd_t  c;
        rhs_word_t reply;
        if (bit_cnt == `FRAME_BITS) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                c     = rx_sr[l];
                reply = '0;
                if (frame_cnt[l] < LOG_DEPTH)
                    frame_log[l][frame_cnt[l]] = rx_sr[l];
                frame_cnt[l]++;
                case (c.op)
                    CMD_CONVERT: reply = {4'(l), c.addr[3:0], dac_code[l], 16'h0000};
                    CMD_WRITE: begin
                        if (c.addr == 8'd3)
                            dac_code[l] = c.data[7:0];
                    end
                    CMD_READ: begin
                        if (c.addr == 8'(`CHIP_ID_REG))
                            reply = 32'd32;                // chip id
                    end
                    default: reply = '0;
                endcase
                for (int d = 0; d < `CONVERT_DELAY - 1; d++)
                    reply_pipe[l][d] = reply_pipe[l][d+1];
                reply_pipe[l][`CONVERT_DELAY-1] = reply;
            end
        end
    end

endmodule

// File: rhs_cmd_sequencer.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module rhs_cmd_sequencer (
    input  logic                clk,
    input  logic                rstn,
    input  logic                config_start,
    input  logic                zcheck_start,
    input  rhs_pkg::zcheck_req_t zcheck_req,
    input  logic                frame_done,
    output logic                busy,
    output logic                done,
    output logic                frame_start,
    output rhs_pkg::rhs_cmd_t   tx_cmd,
    output logic                zcheck_begin,
    output logic                sample_strobe,
    output rhs_pkg::zcheck_req_t zcheck_active_req
);
    import rhs_pkg::*;

    localparam int SLOT_W   = $clog2(`SLOTS_PER_SEQUENCE);
    localparam int STEP_W   = $clog2(`ZCHECK_STEPS);
    localparam int PERIOD_W = $clog2(`ZCHECK_CYCLES);
    localparam int CH_SHIFT = $clog2(`CHANNELS_PER_CHIP);

    localparam logic [SLOT_W-1:0]   SEQ_LAST    = SLOT_W'(`SLOTS_PER_SEQUENCE - 1);
    localparam logic [SLOT_W-1:0]   ZRUN_LAST   = SLOT_W'(`ZCHECK_SLOTS - 1);
    localparam logic [SLOT_W-1:0]   SAMPLE_SLOT = SLOT_W'(`CONVERT_DELAY + 1);
    localparam logic [STEP_W-1:0]   STEP_LAST   = STEP_W'(`ZCHECK_STEPS - 1);
    localparam logic [PERIOD_W-1:0] PERIOD_LAST = PERIOD_W'(`ZCHECK_CYCLES - 1);

    seq_state_e          state;
    logic [SLOT_W-1:0]   slot;
    logic [STEP_W-1:0]   step;
    logic [PERIOD_W-1:0] period;
    rhs_cmd_t            next_cmd;
    logic [CH_SHIFT-1:0] chip_chan;

    function automatic rhs_cmd_t write_cmd(input logic [7:0] addr, input logic [15:0] data);
        rhs_cmd_t c;
        c      = '0;
        c.op   = CMD_WRITE;
        c.addr = addr;
        c.data = data;
        return c;
    endfunction

    // dummy frame, also latches all triggered registers
    function automatic rhs_cmd_t read_id_cmd();
        rhs_cmd_t c;
        c      = '0;
        c.op   = CMD_READ;
        c.u    = 1'b1;
        c.addr = 8'(`CHIP_ID_REG);
        return c;
    endfunction

    function automatic rhs_cmd_t cfg_cmd(input logic [SLOT_W-1:0] idx);
        rhs_cmd_t c;
        c = read_id_cmd();
        case (idx)
            0:  c = write_cmd(8'd32, 16'h0000);          // stim enable a off
            1:  c = write_cmd(8'd33, 16'h0000);          // stim enable b off
            2:  c = write_cmd(8'd38, 16'hFFFF);          // dc amps all on
            3: begin
                c    = '0;                               // clear calibration
                c.op = CMD_CLEAR_CAL;
                c.u  = 1'b1;
                c.d  = 1'b1;
            end
            4:  c = write_cmd(8'd0,  {4'b0, 6'd4, 6'd18}); // adc buffer and mux bias
            5:  c = write_cmd(8'd1,  16'h0080);          // weak miso, unsigned adc
            6:  c = write_cmd(8'd2,  16'h0000);          // zcheck off
            7:  c = write_cmd(8'd3,  16'h0000);          // zcheck dac off
            8:  c = write_cmd(8'd4,  16'h0016);          // upper bandwidth rh1
            9:  c = write_cmd(8'd5,  16'h0017);          // upper bandwidth rh2
            10: c = write_cmd(8'd6,  16'h00A8);          // rl a, 5 Hz
            11: c = write_cmd(8'd7,  16'h000A);          // rl b, 1 kHz
            12: c = write_cmd(8'd8,  16'hFFFF);          // ac amps on
            13: c = write_cmd(8'd10, 16'h0000);          // fast settle open
            14: c = write_cmd(8'd12, 16'hFFFF);          // lower cutoff uses rl a
            15: c = write_cmd(8'd42, 16'h0000);          // stimulators off
            16: c = write_cmd(8'd46, 16'h0000);          // charge recovery open
            17: c = write_cmd(8'd48, 16'h0000);          // recovery dac unconnected
            default: c = read_id_cmd();
        endcase
        return c;
    endfunction

    assign chip_chan = zcheck_active_req.channel[CH_SHIFT-1:0];   // global channel mod 16

    always_comb begin
        next_cmd = read_id_cmd();
        if (state == S_ZSET_LOAD) begin
            if (slot == 0)
                next_cmd = write_cmd(8'd2, {4'b0, chip_chan, 3'b010,
                                            zcheck_active_req.scale, 3'b001});
            else if (slot == 1)
                next_cmd = write_cmd(8'd3, 16'h0000);    // dac at midscale off
        end else if (state == S_ZRUN_LOAD) begin
            if (slot == 0) begin
                next_cmd = write_cmd(8'd3, {8'h00, ZCHECK_SINE[step]});
            end else if (slot == 1) begin
                next_cmd      = '0;
                next_cmd.op   = CMD_CONVERT;
                next_cmd.addr = {4'h0, chip_chan};
            end
        end else begin
            next_cmd = cfg_cmd(slot);
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_CFG_LOAD || state == S_ZSET_LOAD || state == S_ZRUN_LOAD)
            tx_cmd <= next_cmd;                          // held until the next load
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state             <= S_IDLE;
            slot              <= '0;
            step              <= '0;
            period            <= '0;
            zcheck_begin      <= 1'b0;
            zcheck_active_req <= '0;
        end else begin
            zcheck_begin <= 1'b0;
            case (state)
                S_IDLE: begin
                    slot   <= '0;
                    step   <= '0;
                    period <= '0;
                    if (config_start) begin
                        state <= S_CFG_LOAD;             // config has priority
                    end else if (zcheck_start) begin
                        state             <= S_ZSET_LOAD;
                        zcheck_begin      <= 1'b1;
                        zcheck_active_req <= zcheck_req;
                    end
                end
                S_CFG_LOAD:  state <= S_CFG_TX;
                S_CFG_TX:    state <= S_CFG_WAIT;
                S_ZSET_LOAD: state <= S_ZSET_TX;
                S_ZSET_TX:   state <= S_ZSET_WAIT;
                S_ZRUN_LOAD: state <= S_ZRUN_TX;
                S_ZRUN_TX:   state <= S_ZRUN_WAIT;
                S_CFG_WAIT: begin
                    if (frame_done) begin
                        if (slot == SEQ_LAST) begin
                            slot  <= '0;
                            state <= S_DONE;
                        end else begin
                            slot  <= slot + 1'b1;
                            state <= S_CFG_LOAD;
                        end
                    end
                end
                S_ZSET_WAIT: begin
                    if (frame_done) begin
                        if (slot == SEQ_LAST) begin
                            slot  <= '0;
                            state <= S_ZRUN_LOAD;
                        end else begin
                            slot  <= slot + 1'b1;
                            state <= S_ZSET_LOAD;
                        end
                    end
                end
                S_ZRUN_WAIT: begin
                    if (frame_done) begin
                        state <= S_ZRUN_LOAD;
                        if (slot == ZRUN_LAST) begin
                            slot <= '0;
                            if (step == STEP_LAST) begin
                                step <= '0;
                                if (period == PERIOD_LAST)
                                    state <= S_DONE;     // last sine period finished
                                else
                                    period <= period + 1'b1;
                            end else begin
                                step <= step + 1'b1;
                            end
                        end else begin
                            slot <= slot + 1'b1;
                        end
                    end
                end
                S_DONE:  state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    assign frame_start   = (state == S_CFG_TX) || (state == S_ZSET_TX) || (state == S_ZRUN_TX);
    assign busy          = (state != S_IDLE);
    assign done          = (state == S_DONE);
    assign sample_strobe = (state == S_ZRUN_WAIT) && frame_done && (slot == SAMPLE_SLOT);

endmodule

// File: rhs_config.svh
`ifndef RHS_CONFIG_SVH
`define RHS_CONFIG_SVH

// lane and chip geometry
`define NUM_LANES          4
`define CHANNELS_PER_CHIP  16

// spi framing
`define FRAME_BITS         32
`define SPI_HALF_PERIOD    2     // clk cycles per sclk half period
`define CS_GAP             4     // clk cycles cs stays high after a frame

// command sequences
`define SLOTS_PER_SEQUENCE 40    // frames in config or zcheck setup
`define ZCHECK_SLOTS       6     // frames per dac step
`define ZCHECK_STEPS       20    // dac steps per sine period
`define ZCHECK_CYCLES      8     // sine periods per zcheck
`define CONVERT_DELAY      2     // frames until a convert result returns

`define SAMPLE_BITS        16
`define CHIP_ID_REG        255   // reads back as 32

`endif

// File: rhs_controller.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module rhs_controller (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     config_start,
    input  logic                     zcheck_start,
    input  rhs_pkg::zcheck_req_t     zcheck_req,
    output logic                     busy,
    output logic                     done,
    input  logic [7:0]               zcheck_rd_addr,
    output logic [`SAMPLE_BITS-1:0]  zcheck_rd_data,
    output logic                     cs,
    output logic                     sclk,
    output logic [`NUM_LANES-1:0]    mosi,
    input  logic [`NUM_LANES-1:0]    miso
);
    import rhs_pkg::*;

    logic        frame_start;
    logic        frame_done;
    rhs_cmd_t    tx_cmd;
    lane_words_t rx_words;
    logic        zcheck_begin;
    logic        sample_strobe;
    zcheck_req_t zcheck_active_req;

    rhs_cmd_sequencer seq_i (
        .clk               (clk),
        .rstn              (rstn),
        .config_start      (config_start),
        .zcheck_start      (zcheck_start),
        .zcheck_req        (zcheck_req),
        .frame_done        (frame_done),
        .busy              (busy),
        .done              (done),
        .frame_start       (frame_start),
        .tx_cmd            (tx_cmd),
        .zcheck_begin      (zcheck_begin),
        .sample_strobe     (sample_strobe),
        .zcheck_active_req (zcheck_active_req)
    );

    rhs_spi_engine spi_i (
        .clk         (clk),
        .rstn        (rstn),
        .frame_start (frame_start),
        .tx_cmd      (tx_cmd),
        .frame_done  (frame_done),
        .rx_words    (rx_words),
        .cs          (cs),
        .sclk        (sclk),
        .mosi        (mosi),
        .miso        (miso)
    );

    rhs_zcheck_capture cap_i (
        .clk               (clk),
        .rstn              (rstn),
        .zcheck_begin      (zcheck_begin),
        .sample_strobe     (sample_strobe),
        .rx_words          (rx_words),
        .zcheck_active_req (zcheck_active_req),
        .zcheck_rd_addr    (zcheck_rd_addr),
        .zcheck_rd_data    (zcheck_rd_data)
    );

endmodule

// File: rhs_pkg.sv
`include "rhs_config.svh"

package rhs_pkg;

    typedef enum logic [1:0] {
        CMD_CONVERT   = 2'b00,
        CMD_CLEAR_CAL = 2'b01,
        CMD_WRITE     = 2'b10,
        CMD_READ      = 2'b11
    } cmd_op_e;

    // one command frame as shifted out MSB first
    typedef struct packed {
        cmd_op_e     op;
        logic        u;          // update triggered registers
        logic        m;          // clear compliance monitor
        logic        d;          // dc amp sample
        logic        h;          // adc offset removal
        logic [1:0]  spare;
        logic [7:0]  addr;       // register, or channel for a convert
        logic [15:0] data;
    } rhs_cmd_t;

    typedef enum logic [3:0] {
        S_IDLE,
        S_CFG_LOAD,
        S_CFG_TX,
        S_CFG_WAIT,
        S_ZSET_LOAD,
        S_ZSET_TX,
        S_ZSET_WAIT,
        S_ZRUN_LOAD,
        S_ZRUN_TX,
        S_ZRUN_WAIT,
        S_DONE
    } seq_state_e;

    typedef struct packed {
        logic [5:0] channel;     // global channel over all lanes
        logic [1:0] scale;       // zcheck capacitor select
    } zcheck_req_t;

    typedef logic [`FRAME_BITS-1:0] rhs_word_t;

    typedef rhs_word_t [`NUM_LANES-1:0] lane_words_t;

    // one period of the zcheck sine, 1 kHz at 20 steps
    localparam logic [0:`ZCHECK_STEPS-1][7:0] ZCHECK_SINE = '{
        8'd128, 8'd167, 8'd203, 8'd231, 8'd249,
        8'd255, 8'd249, 8'd231, 8'd203, 8'd167,
        8'd128, 8'd89,  8'd53,  8'd25,  8'd7,
        8'd1,   8'd7,   8'd25,  8'd53,  8'd89
    };

endpackage

// File: rhs_spi_engine.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module rhs_spi_engine (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     frame_start,
    input  rhs_pkg::rhs_cmd_t        tx_cmd,
    output logic                     frame_done,
    output rhs_pkg::lane_words_t     rx_words,
    output logic                     cs,
    output logic                     sclk,
    output logic [`NUM_LANES-1:0]    mosi,
    input  logic [`NUM_LANES-1:0]    miso
);
    import rhs_pkg::*;

    localparam int CNT_W = $clog2(2 * `SPI_HALF_PERIOD);
    localparam int BIT_W = $clog2(`FRAME_BITS);
    localparam int GAP_W = $clog2(`CS_GAP);

    localparam logic [CNT_W-1:0] RISE_CNT = CNT_W'(`SPI_HALF_PERIOD - 1);
    localparam logic [CNT_W-1:0] FALL_CNT = CNT_W'(2 * `SPI_HALF_PERIOD - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`FRAME_BITS - 1);
    localparam logic [GAP_W-1:0] LAST_GAP = GAP_W'(`CS_GAP - 1);

    typedef enum logic [1:0] {E_IDLE, E_SHIFT, E_GAP} eng_state_e;

    eng_state_e       state;
    logic [CNT_W-1:0] cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [GAP_W-1:0] gap_cnt;
    logic             load;
    logic             sample;
    logic             shift;

    assign load   = (state == E_IDLE) && frame_start;
    assign sample = (state == E_SHIFT) && (cnt == RISE_CNT);   // sclk rises here
    assign shift  = (state == E_SHIFT) && (cnt == FALL_CNT);   // sclk falls here

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state      <= E_IDLE;
            cs         <= 1'b1;
            sclk       <= 1'b0;
            cnt        <= '0;
            bit_cnt    <= '0;
            gap_cnt    <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            case (state)
                E_IDLE: begin
                    if (frame_start) begin
                        state   <= E_SHIFT;
                        cs      <= 1'b0;
                        cnt     <= '0;
                        bit_cnt <= '0;
                    end
                end
                E_SHIFT: begin
                    cnt <= cnt + 1'b1;
                    if (sample)
                        sclk <= 1'b1;
                    if (shift) begin
                        sclk <= 1'b0;
                        cnt  <= '0;
                        if (bit_cnt == LAST_BIT) begin
                            state   <= E_GAP;
                            cs      <= 1'b1;
                            gap_cnt <= '0;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                        end
                    end
                end
                E_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == LAST_GAP) begin
                        state      <= E_IDLE;
                        frame_done <= 1'b1;
                    end
                end
                default: state <= E_IDLE;
            endcase
        end
    end

    // one shift register pair per lane, all loaded with the same command
    for (genvar l = 0; l < `NUM_LANES; l++) begin : g_lane
        rhs_word_t tx_sr;
        rhs_word_t rx_sr;

        always_ff @(posedge clk) begin
            if (load)
                tx_sr <= tx_cmd;
            else if (shift)
                tx_sr <= {tx_sr[`FRAME_BITS-2:0], 1'b0};
            if (sample)
                rx_sr <= {rx_sr[`FRAME_BITS-2:0], miso[l]};
        end

        assign mosi[l]     = tx_sr[`FRAME_BITS-1] & ~cs;  // idle low between frames
        assign rx_words[l] = rx_sr;
    end

endmodule

// File: rhs_zcheck_capture.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module rhs_zcheck_capture (
    input  logic                        clk,
    input  logic                        rstn,
    input  logic                        zcheck_begin,
    input  logic                        sample_strobe,
    input  rhs_pkg::lane_words_t        rx_words,
    input  rhs_pkg::zcheck_req_t        zcheck_active_req,
    input  logic [7:0]                  zcheck_rd_addr,
    output logic [`SAMPLE_BITS-1:0]     zcheck_rd_data
);
    import rhs_pkg::*;

    localparam int DEPTH    = `ZCHECK_STEPS * `ZCHECK_CYCLES;   // 160 samples
    localparam int LANE_W   = $clog2(`NUM_LANES);
    localparam int CH_SHIFT = $clog2(`CHANNELS_PER_CHIP);

    logic [`SAMPLE_BITS-1:0] mem [DEPTH];
    logic [7:0]              wr_ptr;
    logic [LANE_W-1:0]       lane_sel;
    rhs_word_t               lane_word;

    // channel / CHANNELS_PER_CHIP picks the lane that carries it
    assign lane_sel  = zcheck_active_req.channel[CH_SHIFT +: LANE_W];
    assign lane_word = rx_words[lane_sel];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (zcheck_begin) begin
            wr_ptr <= '0;
        end else if (sample_strobe && wr_ptr < DEPTH) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (sample_strobe && !zcheck_begin && wr_ptr < DEPTH)
            mem[wr_ptr] <= lane_word[`FRAME_BITS-1 -: `SAMPLE_BITS];   // adc result half
    end

    // registered read, zero past the end of the buffer
    always_ff @(posedge clk) begin
        if (zcheck_rd_addr < DEPTH)
            zcheck_rd_data <= mem[zcheck_rd_addr];
        else
            zcheck_rd_data <= '0;
    end

endmodule

// File: src.f
+incdir+.
rhs_pkg.sv
rhs_cmd_sequencer.sv
rhs_spi_engine.sv
rhs_zcheck_capture.sv
rhs_controller.sv
rhs_chip_model.sv
rhs_assertions.sv
tb_rhs_controller.sv

// File: tb_rhs_controller.sv
`timescale 1ns/1ps
`include "rhs_config.svh"

module tb_rhs_controller;
    import rhs_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int DRIVE_DELAY   = 2;
    localparam int NUM_SAMPLES   = `ZCHECK_STEPS * `ZCHECK_CYCLES;
    localparam int ZCHECK_FRAMES = `SLOTS_PER_SEQUENCE + NUM_SAMPLES * `ZCHECK_SLOTS;
    localparam int DONE_TIMEOUT  = 200000;
    localparam int BUSY_TIMEOUT  = 20;
    localparam int QUIET_CYCLES  = 300;   // longer than two frames
    localparam int NUM_ROWS      = 5;

    typedef enum logic [1:0] {RUN_CONFIG, RUN_ZCHECK, RUN_BOTH} run_mode_e;

    typedef struct packed {
        run_mode_e  mode;
        logic [5:0] channel;
        logic [1:0] scale;
    } run_row_t;

    localparam run_row_t RUNS [NUM_ROWS] = '{
        '{RUN_CONFIG, 6'd0,  2'd0},
        '{RUN_ZCHECK, 6'd5,  2'd0},
        '{RUN_ZCHECK, 6'd21, 2'd1},
        '{RUN_ZCHECK, 6'd63, 2'd2},
        '{RUN_BOTH,   6'd10, 2'd3}     // config must win
    };

    localparam logic [7:0] SINE_CODES [`ZCHECK_STEPS] = '{
        8'd128, 8'd167, 8'd203, 8'd231, 8'd249, 8'd255, 8'd249, 8'd231, 8'd203, 8'd167,
        8'd128, 8'd89,  8'd53,  8'd25,  8'd7,   8'd1,   8'd7,   8'd25,  8'd53,  8'd89
    };

    logic                    clk;
    logic                    rstn;
    logic                    config_start;
    logic                    zcheck_start;
    zcheck_req_t             zcheck_req;
    logic                    busy;
    logic                    done;
    logic [7:0]              zcheck_rd_addr;
    logic [`SAMPLE_BITS-1:0] zcheck_rd_data;
    logic                    cs;
    logic                    sclk;
    logic [`NUM_LANES-1:0]   mosi;
    logic [`NUM_LANES-1:0]   miso;

    rhs_controller dut_i (
        .clk            (clk),
        .rstn           (rstn),
        .config_start   (config_start),
        .zcheck_start   (zcheck_start),
        .zcheck_req     (zcheck_req),
        .busy           (busy),
        .done           (done),
        .zcheck_rd_addr (zcheck_rd_addr),
        .zcheck_rd_data (zcheck_rd_data),
        .cs             (cs),
        .sclk           (sclk),
        .mosi           (mosi),
        .miso           (miso)
    );

    rhs_chip_model chip_i (
        .cs   (cs),
        .sclk (sclk),
        .mosi (mosi),
        .miso (miso)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic fail_mismatch(input string msg);
        $display("MISMATCH at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    task automatic fail_plain(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        $display("=== FAIL ===");
        $fatal(1, "stopped at first error");
    endtask

    // sticky flag of the bound pin and status protocol checker
    always @(dut_i.assertions_i.failed) begin
        assert (!dut_i.assertions_i.failed)
            else fail_plain("a pin or status protocol property failed");
    end

    // frame layout: op, u, m, d, h, two spare bits, address, data
    function automatic rhs_word_t write_word(input logic [7:0] addr, input logic [15:0] data);
        return {2'b10, 4'b0000, 2'b00, addr, data};
    endfunction

    function automatic rhs_word_t id_read_word();
        return {2'b11, 4'b1000, 2'b00, 8'd255, 16'h0000};
    endfunction

    function automatic rhs_word_t config_word(input int idx);
        case (idx)
            0:  return write_word(8'd32, 16'h0000);
            1:  return write_word(8'd33, 16'h0000);
            2:  return write_word(8'd38, 16'hFFFF);
            3:  return {2'b01, 4'b1010, 2'b00, 8'd0, 16'h0000};   // clear calibration, u and d
            4:  return write_word(8'd0,  16'h0112);
            5:  return write_word(8'd1,  16'h0080);
            6:  return write_word(8'd2,  16'h0000);
            7:  return write_word(8'd3,  16'h0000);
            8:  return write_word(8'd4,  16'h0016);
            9:  return write_word(8'd5,  16'h0017);
            10: return write_word(8'd6,  16'h00A8);
            11: return write_word(8'd7,  16'h000A);
            12: return write_word(8'd8,  16'hFFFF);
            13: return write_word(8'd10, 16'h0000);
            14: return write_word(8'd12, 16'hFFFF);
            15: return write_word(8'd42, 16'h0000);
            16: return write_word(8'd46, 16'h0000);
            17: return write_word(8'd48, 16'h0000);
            default: return id_read_word();
        endcase
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic check_frames(input run_row_t row);
        int        expected_cnt;
        rhs_word_t expected;
        rhs_word_t got;
        expected_cnt = (row.mode == RUN_ZCHECK) ? ZCHECK_FRAMES : `SLOTS_PER_SEQUENCE;
        for (int l = 0; l < `NUM_LANES; l++) begin
            assert (chip_i.frame_cnt[l] == expected_cnt)
                else fail_mismatch($sformatf("lane %0d got %0d frames, expected %0d",
                                             l, chip_i.frame_cnt[l], expected_cnt));
            for (int i = 0; i < `SLOTS_PER_SEQUENCE; i++) begin
                got = chip_i.frame_log[l][i];
                if (row.mode != RUN_ZCHECK)
                    expected = config_word(i);
                else if (i == 0)                                 // zcheck control
                    expected = write_word(8'd2, (16'(row.channel % 16) << 8) | 16'h0040
                                                | (16'(row.scale) << 3) | 16'h0001);
                else if (i == 1)
                    expected = write_word(8'd3, 16'h0000);
                else
                    expected = id_read_word();
                assert (got == expected && got == chip_i.frame_log[0][i])
                    else fail_mismatch($sformatf("lane %0d frame %0d is %h, expected %h",
                                                 l, i, got, expected));
            end
        end
    endtask

    task automatic check_samples(input run_row_t row);
        logic [15:0] expected;
        logic [3:0]  lane;
        lane = 4'(row.channel / `CHANNELS_PER_CHIP);
        for (int k = 0; k <= NUM_SAMPLES; k++) begin
            zcheck_rd_addr = 8'(k);                              // one past the end reads zero
            next_cycle();
            if (k < NUM_SAMPLES)
                expected = {lane, 4'(row.channel % 16), SINE_CODES[k % `ZCHECK_STEPS]};
            else
                expected = 16'h0000;
            assert (zcheck_rd_data == expected)
                else fail_mismatch($sformatf("sample %0d is %h, expected %h",
                                             k, zcheck_rd_data, expected));
        end
    endtask

    task automatic run_row(input run_row_t row);
        int n;
        chip_i.clear_log();
        zcheck_req   = '{channel: row.channel, scale: row.scale};
        config_start = (row.mode != RUN_ZCHECK);
        zcheck_start = (row.mode != RUN_CONFIG);
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (!busy && n < BUSY_TIMEOUT);
        assert (busy) else fail_plain("busy did not rise after a start");
        config_start = 1'b0;
        zcheck_start = 1'b0;
        next_cycle();
        config_start = 1'b1;                                     // ignored while busy
        zcheck_start = 1'b1;
        next_cycle();
        config_start = 1'b0;
        zcheck_start = 1'b0;
        n = 0;
        while (!done && n < DONE_TIMEOUT) begin
            next_cycle();
            n++;
        end
        assert (done) else fail_plain("timed out waiting for done");
        for (int i = 0; i < QUIET_CYCLES; i++) begin
            next_cycle();
            assert (!busy && !done)
                else fail_mismatch($sformatf("busy=%b done=%b after the run ended", busy, done));
        end
        check_frames(row);
        if (row.mode == RUN_ZCHECK)
            check_samples(row);
    endtask

    initial begin
        rstn           = 1'b0;
        config_start   = 1'b0;
        zcheck_start   = 1'b0;
        zcheck_req     = '0;
        zcheck_rd_addr = 8'd0;
        repeat (16) @(posedge clk);
        #DRIVE_DELAY;
        rstn = 1'b1;
        assert (!busy && !done && !sclk && cs && mosi == '0)
            else fail_mismatch($sformatf("after reset busy=%b done=%b sclk=%b cs=%b mosi=%b",
                                         busy, done, sclk, cs, mosi));
        for (int r = 0; r < NUM_ROWS; r++)
            run_row(RUNS[r]);
        $display("=== PASS ===");
        $finish;
    end

endmodule
